//--- hw/pheapPkg.sv
// Shared widths, types and constants of the pipelined heap queue
// Entry and key/value pack and unpack functions
`default_nettype none

package pheapPkg;

    localparam int KEY_WIDTH   = 16;
    localparam int VALUE_WIDTH = 8;
    localparam int CAP_WIDTH   = 8;

    typedef logic [KEY_WIDTH-1:0]               keyT;
    typedef logic [VALUE_WIDTH-1:0]             valueT;
    typedef logic [KEY_WIDTH+VALUE_WIDTH-1:0]   kvT;
    typedef logic [CAP_WIDTH-1:0]               capT;
    // Layout is {active, capacity, key, value}
    typedef logic [CAP_WIDTH+KEY_WIDTH+VALUE_WIDTH:0] entryT;

    typedef logic opT;
    localparam opT OP_ENQ = 1'b0;
    localparam opT OP_DEQ = 1'b1;

    typedef logic [1:0] statusT;
    localparam statusT ST_WAIT = 2'd0;
    localparam statusT ST_NEXT = 2'd1;
    localparam statusT ST_DONE = 2'd2;

    localparam kvT    KV_EMPTY    = '0;
    localparam entryT ENTRY_EMPTY = '0;

    function automatic entryT makeEntry(logic flag, capT cap, kvT kv);
        return {flag, cap, kv};
    endfunction

    function automatic logic entryActive(entryT e);
        return e[CAP_WIDTH+KEY_WIDTH+VALUE_WIDTH];
    endfunction

    function automatic capT entryCap(entryT e);
        return e[KEY_WIDTH+VALUE_WIDTH +: CAP_WIDTH];
    endfunction

    function automatic kvT entryKv(entryT e);
        return e[KEY_WIDTH+VALUE_WIDTH-1:0];
    endfunction

    function automatic keyT kvKey(kvT kv);
        return kv[VALUE_WIDTH +: KEY_WIDTH];
    endfunction

    function automatic valueT kvValue(kvT kv);
        return kv[VALUE_WIDTH-1:0];
    endfunction

    function automatic keyT entryKey(entryT e);
        return kvKey(entryKv(e));
    endfunction

    // Free room of an empty subtree rooted at the given level
    function automatic capT subtreeSize(int level, int levels);
        return capT'((1 << (levels - level + 1)) - 1);
    endfunction

endpackage

`default_nettype wire

//--- hw/levelMem.sv
// Flop-based entry memory of one heap level
// Registered single-entry and child-pair reads, synchronous write
`default_nettype none

module levelMem #(
    parameter int LEVEL  = 2,
    parameter int LEVELS = 4,
    localparam int PAIR_W = (LEVEL > 2) ? LEVEL - 2 : 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [LEVEL-2:0]        topAddr,
    output pheapPkg::entryT         topEntry,
    input  logic [PAIR_W-1:0]       pairAddr,
    output pheapPkg::entryT         leftEntry,
    output pheapPkg::entryT         rightEntry,
    input  logic                    wen,
    input  logic [LEVEL-2:0]        wrAddr,
    input  pheapPkg::entryT         wrEntry
);

    localparam int DEPTH = 1 << (LEVEL - 1);

    pheapPkg::entryT entries [DEPTH];
    logic [LEVEL-2:0] leftIdx;
    logic [LEVEL-2:0] rightIdx;

    // Children of parent p sit at 2p and 2p+1
    generate
        if (LEVEL > 2) begin : gPairIdx
            assign leftIdx  = {pairAddr, 1'b0};
            assign rightIdx = {pairAddr, 1'b1};
        end else begin : gRootPair
            // Level 2 holds only the two children of the root
            assign leftIdx  = 1'b0;
            assign rightIdx = 1'b1;
        end
    endgenerate

    //----------------------------------------
    // Storage
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            // Empty entries start with the room of their whole subtree
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= pheapPkg::makeEntry(1'b0,
                    pheapPkg::subtreeSize(LEVEL, LEVELS), pheapPkg::KV_EMPTY);
            end
        end else if (wen) begin
            entries[wrAddr] <= wrEntry;
        end
    end

    //----------------------------------------
    // Read ports
    //----------------------------------------
    always_ff @(posedge clk) begin
        topEntry   <= entries[topAddr];
        leftEntry  <= entries[leftIdx];
        rightEntry <= entries[rightIdx];
    end

endmodule

`default_nettype wire

//--- hw/rootLevel.sv
// Level 1 controller of the heap
// Keeps the top entry in a register and starts every operation
`default_nettype none

module rootLevel #(
    parameter int LEVELS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  pheapPkg::opT        op,
    input  pheapPkg::kvT        inKv,
    input  pheapPkg::entryT     leftEntry,
    input  pheapPkg::entryT     rightEntry,
    output pheapPkg::statusT    status,
    output logic                active,
    output pheapPkg::kvT        outKv,
    output logic                nextPos,
    output pheapPkg::entryT     rootEntry
);

    typedef enum logic {IDLE, SET} stateT;

    stateT state;
    stateT nextState;
    pheapPkg::kvT kvReg;
    pheapPkg::entryT topReg;
    pheapPkg::entryT newTop;
    pheapPkg::capT topCap;
    logic pickRight;

    assign rootEntry = topReg;
    assign active    = (state == SET);
    assign topCap    = pheapPkg::entryCap(topReg);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            topReg <= pheapPkg::makeEntry(1'b0, pheapPkg::subtreeSize(1, LEVELS),
                pheapPkg::KV_EMPTY);
        end else begin
            state <= nextState;
            if (state == SET) begin
                topReg <= newTop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            kvReg <= inKv;
        end
    end

    //----------------------------------------
    // Enqueue and dequeue step
    //----------------------------------------
    always_comb begin
        nextState = IDLE;
        status    = pheapPkg::ST_WAIT;
        outKv     = pheapPkg::KV_EMPTY;
        nextPos   = 1'b0;
        newTop    = topReg;
        pickRight = 1'b0;
        if (state == IDLE) begin
            if (start) begin
                nextState = SET;
            end
        end else if (op == pheapPkg::OP_ENQ) begin
            if (!pheapPkg::entryActive(topReg)) begin
                newTop = pheapPkg::makeEntry(1'b1, topCap - 1'b1, kvReg);
                status = pheapPkg::ST_DONE;
            end else begin
                // Larger key stays, the smaller one moves down
                if (pheapPkg::kvKey(kvReg) > pheapPkg::entryKey(topReg)) begin
                    newTop = pheapPkg::makeEntry(1'b1, topCap - 1'b1, kvReg);
                    outKv  = pheapPkg::entryKv(topReg);
                end else begin
                    newTop = pheapPkg::makeEntry(1'b1, topCap - 1'b1,
                        pheapPkg::entryKv(topReg));
                    outKv  = kvReg;
                end
                nextPos = pheapPkg::entryCap(rightEntry) > pheapPkg::entryCap(leftEntry);
                status  = pheapPkg::ST_NEXT;
            end
        end else begin
            outKv = pheapPkg::entryKv(topReg);
            pickRight = pheapPkg::entryActive(rightEntry) &&
                (!pheapPkg::entryActive(leftEntry) ||
                 pheapPkg::entryKey(rightEntry) > pheapPkg::entryKey(leftEntry));
            if (!pheapPkg::entryActive(leftEntry) && !pheapPkg::entryActive(rightEntry)) begin
                newTop = pheapPkg::makeEntry(1'b0, topCap + 1'b1, pheapPkg::KV_EMPTY);
                status = pheapPkg::ST_DONE;
            end else begin
                newTop = pheapPkg::makeEntry(1'b1, topCap + 1'b1,
                    pheapPkg::entryKv(pickRight ? rightEntry : leftEntry));
                nextPos = pickRight;
                status  = pheapPkg::ST_NEXT;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/levelCtrl.sv
// Controller for one heap level below the root
// Reads its entry and both children, writes back and hands on the operation
`default_nettype none

module levelCtrl #(
    parameter int LEVEL  = 2,
    parameter int LEVELS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  pheapPkg::opT        op,
    input  logic [LEVEL-2:0]    startPos,
    input  pheapPkg::kvT        inKv,
    input  pheapPkg::entryT     topEntry,
    input  pheapPkg::entryT     leftEntry,
    input  pheapPkg::entryT     rightEntry,
    output logic [LEVEL-2:0]    readAddr,
    output logic [LEVEL-2:0]    pairAddr,
    output logic [LEVEL-2:0]    wrAddr,
    output logic                wen,
    output pheapPkg::entryT     wrEntry,
    output pheapPkg::statusT    status,
    output pheapPkg::kvT        outKv,
    output logic [LEVEL-1:0]    nextPos
);

    localparam bit IS_BOTTOM = (LEVEL == LEVELS);

    typedef enum logic {READ_MEM, SET_OUT} stateT;

    stateT state;
    stateT nextState;
    logic [LEVEL-2:0] posReg;
    pheapPkg::kvT kvReg;
    pheapPkg::entryT leftEff;
    pheapPkg::entryT rightEff;
    pheapPkg::capT topCap;
    logic pickRight;
    logic leftAct;
    logic rightAct;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= READ_MEM;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == READ_MEM && start) begin
            posReg <= startPos;
            kvReg  <= inKv;
        end
    end

    // Reads are issued while the start strobe is present, so the incoming
    // position addresses memory until it has been captured
    assign readAddr = (state == READ_MEM) ? startPos : posReg;
    assign pairAddr = readAddr;
    assign wrAddr   = posReg;

    // The bottom level has no children
    assign leftEff  = IS_BOTTOM ? pheapPkg::ENTRY_EMPTY : leftEntry;
    assign rightEff = IS_BOTTOM ? pheapPkg::ENTRY_EMPTY : rightEntry;
    assign leftAct  = pheapPkg::entryActive(leftEff);
    assign rightAct = pheapPkg::entryActive(rightEff);
    assign topCap   = pheapPkg::entryCap(topEntry);

    //----------------------------------------
    // Enqueue and dequeue step
    //----------------------------------------
    always_comb begin
        nextState = READ_MEM;
        status    = pheapPkg::ST_WAIT;
        outKv     = pheapPkg::KV_EMPTY;
        nextPos   = {posReg, 1'b0};
        wen       = 1'b0;
        wrEntry   = topEntry;
        pickRight = 1'b0;
        if (state == READ_MEM) begin
            if (start) begin
                nextState = SET_OUT;
            end
        end else begin
            wen = 1'b1;
            if (op == pheapPkg::OP_ENQ) begin
                if (!pheapPkg::entryActive(topEntry)) begin
                    wrEntry = pheapPkg::makeEntry(1'b1, topCap - 1'b1, kvReg);
                    status  = pheapPkg::ST_DONE;
                end else begin
                    if (pheapPkg::kvKey(kvReg) > pheapPkg::entryKey(topEntry)) begin
                        wrEntry = pheapPkg::makeEntry(1'b1, topCap - 1'b1, kvReg);
                        outKv   = pheapPkg::entryKv(topEntry);
                    end else begin
                        wrEntry = pheapPkg::makeEntry(1'b1, topCap - 1'b1,
                            pheapPkg::entryKv(topEntry));
                        outKv   = kvReg;
                    end
                    // Head for the child with more room, left on a tie
                    pickRight = pheapPkg::entryCap(rightEff) > pheapPkg::entryCap(leftEff);
                    nextPos   = {posReg, pickRight};
                    status    = IS_BOTTOM ? pheapPkg::ST_DONE : pheapPkg::ST_NEXT;
                end
            end else begin
                outKv = pheapPkg::entryKv(topEntry);
                pickRight = rightAct &&
                    (!leftAct || pheapPkg::entryKey(rightEff) > pheapPkg::entryKey(leftEff));
                if (!leftAct && !rightAct) begin
                    wrEntry = pheapPkg::makeEntry(1'b0, topCap + 1'b1, pheapPkg::KV_EMPTY);
                    status  = pheapPkg::ST_DONE;
                end else begin
                    wrEntry = pheapPkg::makeEntry(1'b1, topCap + 1'b1,
                        pheapPkg::entryKv(pickRight ? rightEff : leftEff));
                    nextPos = {posReg, pickRight};
                    status  = pheapPkg::ST_NEXT;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pheapQueue.sv
// Top level of the pipelined heap priority queue
// Root controller, level memories and controllers, result and status flags
`default_nettype none

module pheapQueue #(
    parameter int LEVELS = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  pheapPkg::opT    op,
    input  pheapPkg::kvT    inKv,
    output logic            busy,
    output logic            resultValid,
    output pheapPkg::kvT    resultKv,
    output logic            full,
    output logic            empty
);

    pheapPkg::opT opReg;
    pheapPkg::entryT rootEntry;
    logic accept;
    logic rootNext;

    // Per-level chain signals, indexed by level
    pheapPkg::statusT levStatus [1:LEVELS];
    pheapPkg::kvT     levKv     [1:LEVELS];
    logic [LEVELS-1:0] levPos   [1:LEVELS];
    logic             levActive [1:LEVELS];
    // Children seen by level L and the pair address it drives
    pheapPkg::entryT  pairLeft  [1:LEVELS];
    pheapPkg::entryT  pairRight [1:LEVELS];
    logic [LEVELS-1:0] pairAddrs [1:LEVELS];

    assign full  = pheapPkg::entryActive(rootEntry) && (pheapPkg::entryCap(rootEntry) == '0);
    assign empty = !pheapPkg::entryActive(rootEntry);

    assign accept = start && !busy &&
        !(op == pheapPkg::OP_ENQ && full) && !(op == pheapPkg::OP_DEQ && empty);

    always_ff @(posedge clk) begin
        if (rst) begin
            opReg <= pheapPkg::OP_ENQ;
        end else if (accept) begin
            opReg <= op;
        end
    end

    //----------------------------------------
    // Level 1
    //----------------------------------------
    rootLevel #(.LEVELS(LEVELS)) root (
        .clk(clk), .rst(rst), .start(accept), .op(opReg), .inKv(inKv),
        .leftEntry(pairLeft[1]), .rightEntry(pairRight[1]),
        .status(levStatus[1]), .active(levActive[1]), .outKv(levKv[1]),
        .nextPos(rootNext), .rootEntry(rootEntry)
    );

    assign levPos[1]    = LEVELS'(rootNext);
    assign pairAddrs[1] = '0;
    assign pairLeft[LEVELS]  = pheapPkg::ENTRY_EMPTY;
    assign pairRight[LEVELS] = pheapPkg::ENTRY_EMPTY;

    //----------------------------------------
    // Levels 2 to LEVELS
    //----------------------------------------
    generate
        for (genvar L = 2; L <= LEVELS; L++) begin : gLevel
            localparam int PW = (L > 2) ? L - 2 : 1;

            logic [L-2:0] readAddr;
            logic [L-2:0] pairAddr;
            logic [L-2:0] wrAddr;
            logic [L-1:0] nextPos;
            logic wen;
            pheapPkg::entryT wrEntry;
            pheapPkg::entryT topEntry;

            levelMem #(.LEVEL(L), .LEVELS(LEVELS)) mem (
                .clk(clk), .rst(rst), .topAddr(readAddr), .topEntry(topEntry),
                .pairAddr(pairAddrs[L-1][PW-1:0]),
                .leftEntry(pairLeft[L-1]), .rightEntry(pairRight[L-1]),
                .wen(wen), .wrAddr(wrAddr), .wrEntry(wrEntry)
            );

            levelCtrl #(.LEVEL(L), .LEVELS(LEVELS)) ctrl (
                .clk(clk), .rst(rst), .start(levStatus[L-1] == pheapPkg::ST_NEXT),
                .op(opReg), .startPos(levPos[L-1][L-2:0]), .inKv(levKv[L-1]),
                .topEntry(topEntry), .leftEntry(pairLeft[L]), .rightEntry(pairRight[L]),
                .readAddr(readAddr), .pairAddr(pairAddr), .wrAddr(wrAddr),
                .wen(wen), .wrEntry(wrEntry), .status(levStatus[L]),
                .outKv(levKv[L]), .nextPos(nextPos)
            );

            assign pairAddrs[L] = LEVELS'(pairAddr);
            assign levPos[L]    = LEVELS'(nextPos);
            // A level reports WAIT in every cycle except its set-output cycle
            assign levActive[L] = (levStatus[L] != pheapPkg::ST_WAIT);
        end
    endgenerate

    always_comb begin
        busy = 1'b0;
        for (int i = 1; i <= LEVELS; i++) begin
            busy = busy | levActive[i];
        end
    end

    // The root emits the dequeued pair during its set cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= levActive[1] && (opReg == pheapPkg::OP_DEQ);
        end
    end

    always_ff @(posedge clk) begin
        resultKv <= levKv[1];
    end

endmodule

`default_nettype wire

//--- testbench/pheapQueue_props.sv
// Concurrent assertions on the heap queue top level
// Bound into every pheapQueue instance
`default_nettype none

module pheapQueueProps (
    input logic         clk,
    input logic         rst,
    input logic         busy,
    input logic         resultValid,
    input logic         full,
    input logic         empty,
    input pheapPkg::opT opReg
);

    timeunit 1ns;
    timeprecision 100ps;

    resultPulse: assert property (@(posedge clk) disable iff (rst)
        resultValid |=> !resultValid)
        else $error("resultValid lasted longer than one cycle");

    // One operation moves the count by a single entry, so full never meets empty
    fullNotEmpty: assert property (@(posedge clk) disable iff (rst)
        (full |=> !empty) and (empty |=> !full))
        else $error("full and empty high together or in neighboring cycles");

    resultOnDequeue: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> opReg == pheapPkg::OP_DEQ)
        else $error("resultValid raised by an operation other than dequeue");

    idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else $error("busy high right after reset release");

endmodule

bind pheapQueue pheapQueueProps props (
    .clk(clk), .rst(rst), .busy(busy), .resultValid(resultValid),
    .full(full), .empty(empty), .opReg(opReg)
);

`default_nettype wire

//--- testbench/pheapQueueTb.sv
// Directed testbench of the pipelined heap priority queue
// Queue reference model, compare tasks, directed tests and closing summary
`default_nettype none

module pheapQueueTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LEVELS   = 3;
    localparam int CAPACITY = 7;
    localparam int TIMEOUT  = 40;

    logic clk;
    logic rst;
    logic start;
    pheapPkg::opT op;
    pheapPkg::kvT inKv;
    logic busy;
    logic resultValid;
    pheapPkg::kvT resultKv;
    logic full;
    logic empty;

    // Pairs that the queue should hold, in arrival order
    pheapPkg::kvT model [$];
    logic [31:0] rngState;
    int errorCount;
    int timeoutCount;
    string testName;

    pheapQueue #(.LEVELS(LEVELS)) dut (
        .clk(clk), .rst(rst), .start(start), .op(op), .inKv(inKv),
        .busy(busy), .resultValid(resultValid), .resultKv(resultKv),
        .full(full), .empty(empty)
    );

    always #10 clk = ~clk;

    // Last resort if the DUT stalls somewhere the wait loops do not cover
    initial begin
        #1ms;
        $display("Simulation time limit reached before the tests ended");
        $display("Simulation failed");
        $finish;
    end

    //----------------------------------------
    // Helpers
    //----------------------------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Key sits in the upper bits of a pair
    function automatic pheapPkg::keyT keyOf(pheapPkg::kvT kv);
        return kv[pheapPkg::KEY_WIDTH+pheapPkg::VALUE_WIDTH-1 -: pheapPkg::KEY_WIDTH];
    endfunction

    task automatic checkKey(string what, pheapPkg::keyT expected, pheapPkg::keyT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: %s expected %h, actual %h",
                testName, what, expected, actual);
        end
    endtask

    task automatic checkKv(string what, pheapPkg::kvT expected, pheapPkg::kvT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: %s expected %h, actual %h",
                testName, what, expected, actual);
        end
    endtask

    task automatic checkFlag(string what, logic expected, logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: %s expected %b, actual %b",
                testName, what, expected, actual);
        end
    endtask

    task automatic reportTimeout(string what);
        errorCount++;
        timeoutCount++;
        $display("%s: gave up after %0d cycles waiting for %s", testName, TIMEOUT, what);
    endtask

    // Called and returns 2 ns after a rising edge
    task automatic pulseStart(pheapPkg::opT opcode, pheapPkg::kvT kv);
        start = 1'b1;
        op    = opcode;
        inKv  = kv;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic waitIdle(string what);
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (busy) begin
            reportTimeout(what);
        end
    endtask

    task automatic checkLevels();
        checkFlag("empty", model.size() == 0, empty);
        checkFlag("full", model.size() == CAPACITY, full);
    endtask

    // Compare a dequeued pair with the largest key of the model and remove it
    task automatic matchModel(pheapPkg::kvT got);
        int best;
        int ties;
        int hit;
        best = 0;
        ties = 0;
        hit  = -1;
        for (int i = 1; i < model.size(); i++) begin
            if (keyOf(model[i]) > keyOf(model[best])) begin
                best = i;
            end
        end
        foreach (model[i]) begin
            if (keyOf(model[i]) == keyOf(model[best])) begin
                ties++;
                if (model[i] === got && hit < 0) begin
                    hit = i;
                end
            end
        end
        if (ties == 1) begin
            checkKv("dequeued pair", model[best], got);
        end else begin
            checkKey("dequeued key", keyOf(model[best]), keyOf(got));
        end
        model.delete((hit >= 0) ? hit : best);
    endtask

    task automatic enqueueOne(pheapPkg::kvT kv);
        logic accepted;
        accepted = (model.size() < CAPACITY);
        pulseStart(pheapPkg::OP_ENQ, kv);
        checkFlag("busy after enqueue strobe", accepted, busy);
        if (accepted) begin
            model.push_back(kv);
        end
        waitIdle("end of enqueue");
    endtask

    task automatic dequeueOne();
        logic accepted;
        logic seen;
        int cycles;
        pheapPkg::kvT got;
        accepted = (model.size() > 0);
        seen     = 1'b0;
        cycles   = 0;
        got      = '0;
        pulseStart(pheapPkg::OP_DEQ, '0);
        checkFlag("busy after dequeue strobe", accepted, busy);
        while ((busy || (accepted && !seen)) && cycles < TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
            if (resultValid) begin
                seen = 1'b1;
                got  = resultKv;
            end
        end
        if (busy || (accepted && !seen)) begin
            reportTimeout("dequeue result and idle");
        end
        checkFlag("result pulse", accepted, seen);
        if (accepted && seen) begin
            matchModel(got);
        end else if (accepted) begin
            model.delete(0);
        end
    endtask

    task automatic drainQueue();
        int n;
        n = model.size();
        repeat (n) begin
            dequeueOne();
            checkLevels();
        end
    endtask

    task automatic watchQuiet(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            checkFlag("busy stays low", 1'b0, busy);
            checkFlag("no result pulse", 1'b0, resultValid);
        end
    endtask

    // A second strobe lands while the root is idle again but a lower level
    // is still working on the enqueue
    task automatic enqueueWithIntruder(pheapPkg::kvT kv, pheapPkg::opT intruderOp,
            pheapPkg::kvT intruderKv);
        pulseStart(pheapPkg::OP_ENQ, kv);
        model.push_back(kv);
        checkFlag("busy after enqueue strobe", 1'b1, busy);
        @(posedge clk);
        #2;
        checkFlag("busy before second strobe", 1'b1, busy);
        pulseStart(intruderOp, intruderKv);
        waitIdle("end of enqueue");
    endtask

    //----------------------------------------
    // Tests
    //----------------------------------------
    task automatic testResetState();
        testName = "reset state";
        checkLevels();
        dequeueOne();
        watchQuiet(TIMEOUT);
        checkLevels();
    endtask

    task automatic testAscending();
        testName = "ascending fill";
        for (int i = 0; i < 5; i++) begin
            enqueueOne({pheapPkg::keyT'(100 + 37 * i), pheapPkg::valueT'(8'ha0 + i)});
            checkLevels();
        end
        drainQueue();
        checkFlag("empty after drain", 1'b1, empty);
    endtask

    task automatic testFull();
        testName = "full queue";
        // Distinct keys in scrambled order
        for (int i = 0; i < CAPACITY; i++) begin
            enqueueOne({pheapPkg::keyT'(600 - ((i * 5) % 7) * 40), pheapPkg::valueT'(8'h10 + i)});
        end
        checkFlag("full after seven", 1'b1, full);
        enqueueOne({16'hffff, 8'hff});
        checkLevels();
        drainQueue();
    endtask

    task automatic testRandom();
        logic [31:0] r;
        testName = "random mix";
        repeat (200) begin
            r = xorshift32();
            // Small key range so that equal keys show up
            if (model.size() == 0 || (model.size() < CAPACITY && r[1:0] != 2'b00)) begin
                enqueueOne({pheapPkg::keyT'(r[20:16]), pheapPkg::valueT'(r[15:8])});
            end else begin
                dequeueOne();
            end
            checkLevels();
        end
        drainQueue();
    endtask

    task automatic testBusyStart();
        testName = "start while busy";
        for (int i = 0; i < 3; i++) begin
            enqueueOne({pheapPkg::keyT'(16'h0200 + 16 * i), pheapPkg::valueT'(8'h50 + i)});
        end
        enqueueWithIntruder({16'h0010, 8'h77}, pheapPkg::OP_ENQ, {16'hfff0, 8'hee});
        checkLevels();
        enqueueWithIntruder({16'h0300, 8'h66}, pheapPkg::OP_DEQ, '0);
        checkLevels();
        drainQueue();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        op           = pheapPkg::OP_ENQ;
        inKv         = '0;
        errorCount   = 0;
        timeoutCount = 0;
        rngState     = 32'h2fda_550a;
        testName     = "reset";
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        testResetState();
        testAscending();
        testFull();
        testRandom();
        testBusyStart();
        $display("Summary: %0d errors, %0d of them timeouts", errorCount, timeoutCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pheapQueue.f
hw/pheapPkg.sv
hw/levelMem.sv
hw/rootLevel.sv
hw/levelCtrl.sv
hw/pheapQueue.sv
testbench/pheapQueue_props.sv
testbench/pheapQueueTb.sv

//--- Bender.yml
package:
  name: pheap_queue

sources:
  - files:
      - hw/pheapPkg.sv
      - hw/levelMem.sv
      - hw/rootLevel.sv
      - hw/levelCtrl.sv
      - hw/pheapQueue.sv
  - target: test
    files:
      - testbench/pheapQueue_props.sv
      - testbench/pheapQueueTb.sv
